//--- src/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// csr numbers
`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_ECFG    14'h004
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_BADV    14'h007
`define CSR_EENTRY  14'h00c
`define CSR_SAVE0   14'h030
`define CSR_SAVE1   14'h031
`define CSR_SAVE2   14'h032
`define CSR_SAVE3   14'h033
`define CSR_TID     14'h040
`define CSR_TCFG    14'h041
`define CSR_TVAL    14'h042
`define CSR_TICLR   14'h044
`define CSR_LLBCTL  14'h060

// crmd / prmd fields
`define PLV         1:0
`define IE          2
`define DA          3
`define PG          4
`define DATF        6:5
`define DATM        8:7
`define PPLV        1:0
`define PIE         2

// ecfg / estat fields
`define LIE         12:0
`define LIE_WMASK   13'h1bff
`define IS          12:0
`define IS_SW       1:0
`define IS_HW       9:2
`define IS_TI       11
`define ECODE       21:16
`define ESUBCODE    30:22
`define ECODE_W     6
`define ESUBCODE_W  9
`define EENTRY_VA   31:6

// timer and ll-bit fields
`define TCFG_EN       0
`define TCFG_PERIODIC 1
`define TCFG_INITVAL  31:2
`define TICLR_CLR     0
`define LLBCTL_WCLLB  1
`define LLBCTL_KLO    2

// countdown parked here once a one-shot run ends
`define TVAL_IDLE   32'hffff_ffff

`endif

//--- src/csr_pkg.sv
`include "csr_settings.svh"

package csr_pkg;

  typedef logic [13:0] csr_addr_t;
  typedef logic [31:0] csr_word_t;
  typedef logic [1:0]  plv_t;

  typedef logic [`ECODE_W-1:0]    ecode_t;
  typedef logic [`ESUBCODE_W-1:0] esubcode_t;

  // same bit order as estat.is and ecfg.lie
  typedef logic [12:0] int_vec_t;

  typedef logic [7:0]  hw_int_t;

  // one register write from the core
  typedef struct packed {
    logic      en;
    csr_addr_t addr;
    csr_word_t data;
  } csr_wr_t;

  // exception commit
  typedef struct packed {
    logic      excp;
    ecode_t    code;
    esubcode_t subcode;
    // return address for era
    csr_word_t epc;
    logic      badv_valid;
    csr_word_t badv_addr;
  } exc_event_t;

  // ll/sc update of the load-linked bit
  typedef struct packed {
    logic en;
    logic value;
  } llbit_wr_t;

endpackage

//--- src/csr_exc_regs.sv
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_exc_regs import csr_pkg::*; (
  input  logic       clk,
  input  logic       resetn,
  input  csr_addr_t  raddr,
  input  csr_wr_t    csr_wr,
  input  exc_event_t exc,
  input  logic       ertn,
  input  hw_int_t    hw_int,
  input  logic       ti_pending,
  output csr_word_t  rd_data,
  output logic       has_int,
  output plv_t       plv,
  output csr_word_t  eentry,
  output csr_word_t  era
);

  logic crmd_we;
  logic prmd_we;
  logic ecfg_we;
  logic estat_we;
  logic era_we;
  logic badv_we;
  logic eentry_we;

  plv_t        crmd_plv;
  logic        crmd_ie;
  logic        crmd_da;
  logic        crmd_pg;
  logic [1:0]  crmd_datf;
  logic [1:0]  crmd_datm;
  plv_t        prmd_pplv;
  logic        prmd_pie;
  int_vec_t    ecfg_lie;
  logic [1:0]  is_sw;
  hw_int_t     is_hw;
  int_vec_t    is_vec;
  ecode_t      estat_ecode;
  esubcode_t   estat_esubcode;
  csr_word_t   era_q;
  csr_word_t   badv_q;
  logic [25:0] eentry_va;

  csr_word_t crmd_word;
  csr_word_t prmd_word;
  csr_word_t ecfg_word;
  csr_word_t estat_word;

  assign crmd_we   = csr_wr.en && (csr_wr.addr == `CSR_CRMD);
  assign prmd_we   = csr_wr.en && (csr_wr.addr == `CSR_PRMD);
  assign ecfg_we   = csr_wr.en && (csr_wr.addr == `CSR_ECFG);
  assign estat_we  = csr_wr.en && (csr_wr.addr == `CSR_ESTAT);
  assign era_we    = csr_wr.en && (csr_wr.addr == `CSR_ERA);
  assign badv_we   = csr_wr.en && (csr_wr.addr == `CSR_BADV);
  assign eentry_we = csr_wr.en && (csr_wr.addr == `CSR_EENTRY);

  // crmd and prmd
  always_ff @(posedge clk) begin
    if (!resetn) begin
      crmd_plv  <= '0;
      crmd_ie   <= 1'b0;
      crmd_da   <= 1'b1;
      crmd_pg   <= 1'b0;
      crmd_datf <= '0;
      crmd_datm <= '0;
      prmd_pplv <= '0;
      prmd_pie  <= 1'b0;
    end else if (exc.excp) begin
      prmd_pplv <= crmd_plv;
      prmd_pie  <= crmd_ie;
      crmd_plv  <= '0;
      crmd_ie   <= 1'b0;
    end else if (ertn) begin
      crmd_plv <= prmd_pplv;
      crmd_ie  <= prmd_pie;
    end else begin
      if (crmd_we) begin
        crmd_plv  <= csr_wr.data[`PLV];
        crmd_ie   <= csr_wr.data[`IE];
        crmd_da   <= csr_wr.data[`DA];
        crmd_pg   <= csr_wr.data[`PG];
        crmd_datf <= csr_wr.data[`DATF];
        crmd_datm <= csr_wr.data[`DATM];
      end
      if (prmd_we) begin
        prmd_pplv <= csr_wr.data[`PPLV];
        prmd_pie  <= csr_wr.data[`PIE];
      end
    end
  end

  // interrupt enables and status
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ecfg_lie <= '0;
      is_sw    <= '0;
      is_hw    <= '0;
    end else begin
      is_hw <= hw_int;
      if (ecfg_we) begin
        ecfg_lie <= csr_wr.data[`LIE] & `LIE_WMASK;
      end
      if (estat_we) begin
        is_sw <= csr_wr.data[`IS_SW];
      end
    end
  end

  // exception payload
  always_ff @(posedge clk) begin
    if (exc.excp) begin
      estat_ecode    <= exc.code;
      estat_esubcode <= exc.subcode;
      era_q          <= exc.epc;
    end else if (era_we) begin
      era_q <= csr_wr.data;
    end
    // a direct write beats the reported address
    if (badv_we) begin
      badv_q <= csr_wr.data;
    end else if (exc.excp && exc.badv_valid) begin
      badv_q <= exc.badv_addr;
    end
    if (eentry_we) begin
      eentry_va <= csr_wr.data[`EENTRY_VA];
    end
  end

  always_comb begin
    crmd_word        = '0;
    crmd_word[`PLV]  = crmd_plv;
    crmd_word[`IE]   = crmd_ie;
    crmd_word[`DA]   = crmd_da;
    crmd_word[`PG]   = crmd_pg;
    crmd_word[`DATF] = crmd_datf;
    crmd_word[`DATM] = crmd_datm;

    prmd_word        = '0;
    prmd_word[`PPLV] = prmd_pplv;
    prmd_word[`PIE]  = prmd_pie;

    ecfg_word       = '0;
    ecfg_word[`LIE] = ecfg_lie;

    // inter-core bit stays zero
    is_vec         = '0;
    is_vec[`IS_SW] = is_sw;
    is_vec[`IS_HW] = is_hw;
    is_vec[`IS_TI] = ti_pending;

    estat_word            = '0;
    estat_word[`IS]       = is_vec;
    estat_word[`ECODE]    = estat_ecode;
    estat_word[`ESUBCODE] = estat_esubcode;
  end

  always_comb begin
    case (raddr)
      `CSR_CRMD:   rd_data = crmd_word;
      `CSR_PRMD:   rd_data = prmd_word;
      `CSR_ECFG:   rd_data = ecfg_word;
      `CSR_ESTAT:  rd_data = estat_word;
      `CSR_ERA:    rd_data = era_q;
      `CSR_BADV:   rd_data = badv_q;
      `CSR_EENTRY: rd_data = eentry;
      default:     rd_data = '0;
    endcase
  end

  assign has_int = crmd_ie && ((ecfg_lie & is_vec) != '0);
  assign plv     = crmd_plv;
  assign eentry  = {eentry_va, 6'b0};
  assign era     = era_q;

endmodule

//--- src/csr_timer.sv
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_timer import csr_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  input  csr_addr_t   raddr,
  input  csr_wr_t     csr_wr,
  output csr_word_t   rd_data,
  output logic        ti_pending,
  output csr_word_t   tid,
  output logic [63:0] stable_counter
);

  logic tcfg_we;
  logic ticlr_we;
  logic tid_we;
  logic timer_hit;

  logic        tcfg_en;
  logic        tcfg_periodic;
  logic [29:0] tcfg_initval;
  csr_word_t   tcfg_word;
  csr_word_t   tval;
  csr_word_t   tid_q;
  logic [63:0] count_q;

  assign tcfg_we  = csr_wr.en && (csr_wr.addr == `CSR_TCFG);
  assign ticlr_we = csr_wr.en && (csr_wr.addr == `CSR_TICLR);
  assign tid_we   = csr_wr.en && (csr_wr.addr == `CSR_TID);

  assign timer_hit = tcfg_en && (tval == '0);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      tcfg_en <= 1'b0;
    end else if (tcfg_we) begin
      tcfg_en <= csr_wr.data[`TCFG_EN];
    end
  end

  always_ff @(posedge clk) begin
    if (tcfg_we) begin
      tcfg_periodic <= csr_wr.data[`TCFG_PERIODIC];
      tcfg_initval  <= csr_wr.data[`TCFG_INITVAL];
    end
  end

  // countdown; a one-shot run wraps from zero to idle and parks there
  always_ff @(posedge clk) begin
    if (!resetn) begin
      tval <= `TVAL_IDLE;
    end else if (tcfg_we && csr_wr.data[`TCFG_EN]) begin
      tval <= {csr_wr.data[`TCFG_INITVAL], 2'b00};
    end else if (tcfg_en && (tval != `TVAL_IDLE)) begin
      if (timer_hit && tcfg_periodic) begin
        tval <= {tcfg_initval, 2'b00};
      end else begin
        tval <= tval - 32'd1;
      end
    end
  end

  // set wins over a clear in the same cycle
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ti_pending <= 1'b0;
    end else if (timer_hit) begin
      ti_pending <= 1'b1;
    end else if (ticlr_we && csr_wr.data[`TICLR_CLR]) begin
      ti_pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      tid_q   <= '0;
      count_q <= '0;
    end else begin
      count_q <= count_q + 64'd1;
      if (tid_we) begin
        tid_q <= csr_wr.data;
      end
    end
  end

  always_comb begin
    tcfg_word                 = '0;
    tcfg_word[`TCFG_EN]       = tcfg_en;
    tcfg_word[`TCFG_PERIODIC] = tcfg_periodic;
    tcfg_word[`TCFG_INITVAL]  = tcfg_initval;
  end

  // ticlr falls to the default and reads zero
  always_comb begin
    case (raddr)
      `CSR_TID:  rd_data = tid_q;
      `CSR_TCFG: rd_data = tcfg_word;
      `CSR_TVAL: rd_data = tval;
      default:   rd_data = '0;
    endcase
  end

  assign tid            = tid_q;
  assign stable_counter = count_q;

endmodule

//--- src/csr_llbit_save.sv
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_llbit_save import csr_pkg::*; (
  input  logic      clk,
  input  logic      resetn,
  input  csr_addr_t raddr,
  input  csr_wr_t   csr_wr,
  input  logic      ertn,
  input  llbit_wr_t llbit_wr,
  output csr_word_t rd_data
);

  logic      llbctl_we;
  logic      llbit;
  logic      klo;
  csr_word_t llbctl_word;
  csr_word_t save_q [4];

  assign llbctl_we = csr_wr.en && (csr_wr.addr == `CSR_LLBCTL);

  // scratch registers
  always_ff @(posedge clk) begin
    if (csr_wr.en) begin
      case (csr_wr.addr)
        `CSR_SAVE0: save_q[0] <= csr_wr.data;
        `CSR_SAVE1: save_q[1] <= csr_wr.data;
        `CSR_SAVE2: save_q[2] <= csr_wr.data;
        `CSR_SAVE3: save_q[3] <= csr_wr.data;
        default: ;
      endcase
    end
  end

  // klo keeps the ll bit alive across one ertn
  always_ff @(posedge clk) begin
    if (!resetn) begin
      llbit <= 1'b0;
      klo   <= 1'b0;
    end else if (ertn) begin
      if (klo) begin
        klo <= 1'b0;
      end else begin
        llbit <= 1'b0;
      end
    end else if (llbctl_we) begin
      klo <= csr_wr.data[`LLBCTL_KLO];
      if (csr_wr.data[`LLBCTL_WCLLB]) begin
        llbit <= 1'b0;
      end
    end else if (llbit_wr.en) begin
      llbit <= llbit_wr.value;
    end
  end

  // wcllb is write-only
  always_comb begin
    llbctl_word               = '0;
    llbctl_word[0]            = llbit;
    llbctl_word[`LLBCTL_KLO]  = klo;
  end

  always_comb begin
    case (raddr)
      `CSR_SAVE0:  rd_data = save_q[0];
      `CSR_SAVE1:  rd_data = save_q[1];
      `CSR_SAVE2:  rd_data = save_q[2];
      `CSR_SAVE3:  rd_data = save_q[3];
      `CSR_LLBCTL: rd_data = llbctl_word;
      default:     rd_data = '0;
    endcase
  end

endmodule

//--- src/csr_file.sv
`timescale 1ns/1ps

module csr_file import csr_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  input  csr_addr_t   csr_raddr,
  input  csr_wr_t     csr_wr,
  input  exc_event_t  exc,
  input  logic        ertn,
  input  hw_int_t     hw_int,
  input  llbit_wr_t   llbit_wr,
  output csr_word_t   csr_rdata,
  output logic        has_int,
  output plv_t        plv,
  output csr_word_t   eentry,
  output csr_word_t   era,
  output csr_word_t   tid,
  output logic [63:0] stable_counter
);

  csr_word_t rd_exc;
  csr_word_t rd_timer;
  csr_word_t rd_llbit;
  logic      ti_pending;

  csr_exc_regs exc_regs0 (
    .clk        (clk),
    .resetn     (resetn),
    .raddr      (csr_raddr),
    .csr_wr     (csr_wr),
    .exc        (exc),
    .ertn       (ertn),
    .hw_int     (hw_int),
    .ti_pending (ti_pending),
    .rd_data    (rd_exc),
    .has_int    (has_int),
    .plv        (plv),
    .eentry     (eentry),
    .era        (era)
  );

  csr_timer timer0 (
    .clk            (clk),
    .resetn         (resetn),
    .raddr          (csr_raddr),
    .csr_wr         (csr_wr),
    .rd_data        (rd_timer),
    .ti_pending     (ti_pending),
    .tid            (tid),
    .stable_counter (stable_counter)
  );

  csr_llbit_save llbit_save0 (
    .clk      (clk),
    .resetn   (resetn),
    .raddr    (csr_raddr),
    .csr_wr   (csr_wr),
    .ertn     (ertn),
    .llbit_wr (llbit_wr),
    .rd_data  (rd_llbit)
  );

  // blocks return zero for numbers they do not own
  assign csr_rdata = rd_exc | rd_timer | rd_llbit;

endmodule

//--- testbench/tb_csr_file.sv
`timescale 1ns/1ps
`include "csr_settings.svh"

module tb_csr_file import csr_pkg::*; ();

  // the whole run takes under 200 cycles
  localparam int max_cycles = 2000;
  localparam int timer_n    = 2;

  logic        clk;
  logic        resetn;
  csr_addr_t   csr_raddr;
  csr_wr_t     csr_wr;
  exc_event_t  exc;
  logic        ertn;
  hw_int_t     hw_int;
  llbit_wr_t   llbit_wr;
  csr_word_t   csr_rdata;
  logic        has_int;
  plv_t        plv;
  csr_word_t   eentry;
  csr_word_t   era;
  csr_word_t   tid;
  logic [63:0] stable_counter;

  int          cycles;
  logic [31:0] rng;

  csr_file dut0 (
    .clk            (clk),
    .resetn         (resetn),
    .csr_raddr      (csr_raddr),
    .csr_wr         (csr_wr),
    .exc            (exc),
    .ertn           (ertn),
    .hw_int         (hw_int),
    .llbit_wr       (llbit_wr),
    .csr_rdata      (csr_rdata),
    .has_int        (has_int),
    .plv            (plv),
    .eentry         (eentry),
    .era            (era),
    .tid            (tid),
    .stable_counter (stable_counter)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("ERROR at %0t: run did not finish within %0d cycles", $time, max_cycles);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  task automatic csr_write(input csr_addr_t addr, input csr_word_t data);
    csr_wr.en   = 1'b1;
    csr_wr.addr = addr;
    csr_wr.data = data;
    step_cycle();
    csr_wr.en = 1'b0;
  endtask

  // reads are combinational, so a short settle is enough
  task automatic csr_read(input csr_addr_t addr, output csr_word_t data);
    csr_raddr = addr;
    #1;
    data = csr_rdata;
  endtask

  task automatic check_read(input csr_addr_t addr, input csr_word_t exp, input string what);
    csr_word_t data;
    csr_read(addr, data);
    check_value(data, exp, what);
  endtask

  task automatic pulse_ertn();
    ertn = 1'b1;
    step_cycle();
    ertn = 1'b0;
  endtask

  task automatic set_llbit();
    llbit_wr.en    = 1'b1;
    llbit_wr.value = 1'b1;
    step_cycle();
    llbit_wr = '0;
  endtask

  task automatic wait_for_int(input int limit, output int edges);
    edges = 0;
    while (!has_int) begin
      if (edges == limit) begin
        $display("ERROR at %0t: has_int did not rise within %0d cycles", $time, limit);
        $display("RESULT: FAIL");
        $fatal(1);
      end
      step_cycle();
      edges++;
    end
  endtask

  task automatic reset_and_storage();
    csr_word_t   saved [4];
    csr_word_t   word;
    logic [63:0] count0;
    check_read(`CSR_CRMD, 32'h0000_0008, "crmd after reset");
    check_read(`CSR_TVAL, 32'hffff_ffff, "tval after reset");
    check_value(has_int, 1'b0, "has_int after reset");
    for (int i = 0; i < 4; i++) begin
      rng      = xorshift32(rng);
      saved[i] = rng;
      csr_write(csr_addr_t'(`CSR_SAVE0 + i), rng);
    end
    for (int i = 0; i < 4; i++) begin
      check_read(csr_addr_t'(`CSR_SAVE0 + i), saved[i], $sformatf("save%0d readback", i));
    end
    rng  = xorshift32(rng);
    word = rng;
    csr_write(`CSR_TID, word);
    check_read(`CSR_TID, word, "tid readback");
    check_value(tid, word, "tid output");
    rng  = xorshift32(rng);
    word = rng;
    csr_write(`CSR_ERA, word);
    check_read(`CSR_ERA, word, "era readback");
    check_value(era, word, "era output");
    count0 = stable_counter;
    repeat (7) step_cycle();
    check_value(stable_counter - count0, 64'd7, "stable counter step");
  endtask

  task automatic exception_entry_return();
    exc_event_t ev;
    csr_word_t  exp_estat;
    csr_word_t  vec;
    vec = 32'h1c00_8a7f;
    csr_write(`CSR_EENTRY, vec);
    // plv 3 with ie and da
    csr_write(`CSR_CRMD, 32'h0000_000f);
    check_value(plv, 2'd3, "plv before exception");
    ev            = '0;
    ev.excp       = 1'b1;
    ev.code       = 6'h08;
    ev.subcode    = 9'h1a3;
    ev.epc        = 32'h1c00_1234;
    ev.badv_valid = 1'b1;
    ev.badv_addr  = 32'h0bad_f00c;
    exc = ev;
    step_cycle();
    exc = '0;
    exp_estat            = '0;
    exp_estat[`ECODE]    = ev.code;
    exp_estat[`ESUBCODE] = ev.subcode;
    check_value(plv, 2'd0, "plv after exception");
    check_read(`CSR_CRMD, 32'h0000_0008, "crmd after exception");
    check_read(`CSR_PRMD, 32'h0000_0007, "prmd after exception");
    check_read(`CSR_ESTAT, exp_estat, "estat code and subcode");
    check_read(`CSR_ERA, ev.epc, "era readback");
    check_value(era, ev.epc, "era output");
    check_read(`CSR_BADV, ev.badv_addr, "badv readback");
    check_value(eentry, vec & ~32'h3f, "eentry output");
    check_read(`CSR_EENTRY, vec & ~32'h3f, "eentry readback");
    pulse_ertn();
    check_value(plv, 2'd3, "plv after ertn");
    check_read(`CSR_CRMD, 32'h0000_000f, "crmd after ertn");
  endtask

  task automatic interrupt_masking();
    csr_word_t word;
    csr_write(`CSR_CRMD, 32'h0000_000c);
    csr_write(`CSR_ECFG, 32'h0);
    hw_int = 8'h04;
    step_cycle();
    check_value(has_int, 1'b0, "has_int with line and ie, no mask");
    csr_read(`CSR_ESTAT, word);
    check_value(word[`IS_HW], 8'h04, "estat hardware lines");
    csr_write(`CSR_CRMD, 32'h0000_0008);
    // hw line 2 sits at is bit 4
    csr_write(`CSR_ECFG, 32'h1 << 4);
    check_value(has_int, 1'b0, "has_int with ie clear");
    csr_write(`CSR_CRMD, 32'h0000_000c);
    check_value(has_int, 1'b1, "has_int with line, mask and ie");
    hw_int = 8'h00;
    check_value(has_int, 1'b1, "has_int before line sampled low");
    step_cycle();
    check_value(has_int, 1'b0, "has_int after line fell");
    csr_write(`CSR_ECFG, 32'h1);
    check_value(has_int, 1'b0, "has_int with sw mask only");
    csr_write(`CSR_ESTAT, 32'h1);
    check_value(has_int, 1'b1, "has_int from sw bit");
    csr_write(`CSR_ESTAT, 32'h0);
    check_value(has_int, 1'b0, "has_int after sw bit clear");
  endtask

  task automatic timer_interrupt();
    int edges;
    int t_prev;
    csr_write(`CSR_ECFG, 32'h1 << 11);
    csr_write(`CSR_CRMD, 32'h0000_000c);
    check_value(has_int, 1'b0, "has_int before timer start");
    csr_write(`CSR_TCFG, (timer_n << 2) | 32'h1);
    wait_for_int(40, edges);
    // the edge that took the write counts as the first
    check_value(edges + 1, 4 * timer_n + 2, "one-shot interrupt delay");
    check_read(`CSR_TVAL, 32'hffff_ffff, "tval after one-shot");
    repeat (3) step_cycle();
    check_read(`CSR_TVAL, 32'hffff_ffff, "tval stays idle");
    check_value(has_int, 1'b1, "timer pending holds");
    check_read(`CSR_TICLR, 32'h0, "ticlr reads zero");
    csr_write(`CSR_TICLR, 32'h1);
    check_value(has_int, 1'b0, "has_int after ticlr");
    // periodic
    csr_write(`CSR_TCFG, (timer_n << 2) | 32'h3);
    wait_for_int(40, edges);
    check_value(edges + 1, 4 * timer_n + 2, "periodic first interrupt delay");
    t_prev = cycles;
    repeat (2) begin
      csr_write(`CSR_TICLR, 32'h1);
      check_value(has_int, 1'b0, "has_int after periodic clear");
      wait_for_int(40, edges);
      check_value(cycles - t_prev, 4 * timer_n + 1, "periodic interrupt spacing");
      t_prev = cycles;
    end
    csr_write(`CSR_TCFG, 32'h0);
    csr_write(`CSR_TICLR, 32'h1);
    check_value(has_int, 1'b0, "has_int after timer stop");
    csr_write(`CSR_ECFG, 32'h0);
  endtask

  task automatic llbit_control();
    set_llbit();
    check_read(`CSR_LLBCTL, 32'h1, "ll bit set by llbit_wr");
    pulse_ertn();
    check_read(`CSR_LLBCTL, 32'h0, "ll bit cleared by ertn");
    csr_write(`CSR_LLBCTL, 32'h1 << `LLBCTL_KLO);
    check_read(`CSR_LLBCTL, 32'h4, "klo set");
    set_llbit();
    check_read(`CSR_LLBCTL, 32'h5, "ll bit with klo");
    pulse_ertn();
    check_read(`CSR_LLBCTL, 32'h1, "first ertn clears only klo");
    pulse_ertn();
    check_read(`CSR_LLBCTL, 32'h0, "second ertn clears ll bit");
    set_llbit();
    check_read(`CSR_LLBCTL, 32'h1, "ll bit set again");
    csr_write(`CSR_LLBCTL, 32'h1 << `LLBCTL_WCLLB);
    check_read(`CSR_LLBCTL, 32'h0, "wcllb clears ll bit");
  endtask

  initial begin
    resetn    = 1'b0;
    csr_raddr = '0;
    csr_wr    = '0;
    exc       = '0;
    ertn      = 1'b0;
    hw_int    = '0;
    llbit_wr  = '0;
    cycles    = 0;
    rng       = 32'h48204fe7;
    repeat (2) @(posedge clk);
    #1;
    resetn = 1'b1;
    reset_and_storage();
    exception_entry_return();
    interrupt_masking();
    timer_interrupt();
    llbit_control();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- tb.f
+incdir+src
src/csr_pkg.sv
src/csr_exc_regs.sv
src/csr_timer.sv
src/csr_llbit_save.sv
src/csr_file.sv
testbench/tb_csr_file.sv

//--- Bender.yml
package:
  name: csr_file

sources:
  - include_dirs:
      - src
    files:
      - src/csr_pkg.sv
      - src/csr_exc_regs.sv
      - src/csr_timer.sv
      - src/csr_llbit_save.sv
      - src/csr_file.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - testbench/tb_csr_file.sv
